// ==== hw/soc_pkg.sv ====
package soc_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Bus widths
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int addr_w = 32;
  localparam int data_w = 32;
  localparam int strb_w = data_w / 8;

  // AXI response codes, exokay is never produced
  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_slverr = 2'b10,
    resp_decerr = 2'b11
  } resp_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Address map
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam logic [addr_w-1:0] sram_base = 32'h8000_0000;
  localparam int sram_words = 256;
  localparam int sram_idx_w = $clog2(sram_words);

  // 1 KiB window
  localparam logic [addr_w-1:0] sram_hit = 32'hFFFF_FC00;

  // mtime low word at base, high word at base + 4
  localparam logic [addr_w-1:0] clint_base = 32'h0200_0000;
  localparam logic [addr_w-1:0] clint_hit = 32'hFFFF_FFF8;

endpackage

// ==== hw/axi_lite_if.sv ====
`timescale 1ns/1ps

interface axi_lite_if;
  import soc_pkg::*;

  logic              arvalid;
  logic              arready;
  logic [addr_w-1:0] araddr;

  logic              rvalid;
  logic              rready;
  logic [data_w-1:0] rdata;
  resp_t             rresp;

  logic              awvalid;
  logic              awready;
  logic [addr_w-1:0] awaddr;

  logic              wvalid;
  logic              wready;
  logic [data_w-1:0] wdata;
  logic [strb_w-1:0] wstrb;

  logic              bvalid;
  logic              bready;
  resp_t             bresp;

  modport master (
    output arvalid, araddr, rready, awvalid, awaddr, wvalid, wdata, wstrb, bready,
    input  arready, rvalid, rdata, rresp, awready, wready, bvalid, bresp
  );

  modport slave (
    input  arvalid, araddr, rready, awvalid, awaddr, wvalid, wdata, wstrb, bready,
    output arready, rvalid, rdata, rresp, awready, wready, bvalid, bresp
  );

  // Read-only views, ar and r channels
  modport rd_master (output arvalid, araddr, rready, input arready, rvalid, rdata, rresp);
  modport rd_slave (input arvalid, araddr, rready, output arready, rvalid, rdata, rresp);

endinterface

// ==== hw/bus_arbiter.sv ====
`timescale 1ns/1ps

module bus_arbiter (
  input  logic       clock,
  input  logic       rst,
  axi_lite_if.rd_slave fetch,
  axi_lite_if.slave  lsu,
  axi_lite_if.master shared
);

  typedef enum logic [1:0] {
    own_none,
    own_fetch,
    own_lsu
  } owner_t;

  owner_t owner;
  logic   fetch_sel;
  logic   lsu_sel;
  logic   fetch_done;
  logic   lsu_done;

  assign fetch_sel = (owner == own_fetch);
  assign lsu_sel   = (owner == own_lsu);

  // Grant ends on the owner's response handshake
  assign fetch_done = fetch_sel && shared.rvalid && shared.rready;
  assign lsu_done   = lsu_sel && ((shared.rvalid && shared.rready) ||
                                  (shared.bvalid && shared.bready));

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Owner register, load/store has priority
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clock) begin
    if (rst) begin
      owner <= own_none;
    end else begin
      case (owner)
        own_none: begin
          if (lsu.arvalid || lsu.awvalid) begin
            owner <= own_lsu;
          end else if (fetch.arvalid) begin
            owner <= own_fetch;
          end
        end
        own_fetch: begin
          if (fetch_done) begin
            owner <= own_none;
          end
        end
        own_lsu: begin
          if (lsu_done) begin
            owner <= own_none;
          end
        end
        default: owner <= own_none;
      endcase
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Request mux
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign shared.arvalid = fetch_sel ? fetch.arvalid : (lsu_sel && lsu.arvalid);
  assign shared.araddr  = fetch_sel ? fetch.araddr : lsu.araddr;
  assign shared.rready  = fetch_sel ? fetch.rready : (lsu_sel && lsu.rready);

  // Only the load/store port writes
  assign shared.awvalid = lsu_sel && lsu.awvalid;
  assign shared.awaddr  = lsu.awaddr;
  assign shared.wvalid  = lsu_sel && lsu.wvalid;
  assign shared.wdata   = lsu.wdata;
  assign shared.wstrb   = lsu.wstrb;
  assign shared.bready  = lsu_sel && lsu.bready;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Response demux
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign fetch.arready = fetch_sel && shared.arready;
  assign fetch.rvalid  = fetch_sel && shared.rvalid;
  assign fetch.rdata   = shared.rdata;
  assign fetch.rresp   = shared.rresp;

  assign lsu.arready = lsu_sel && shared.arready;
  assign lsu.rvalid  = lsu_sel && shared.rvalid;
  assign lsu.rdata   = shared.rdata;
  assign lsu.rresp   = shared.rresp;
  assign lsu.awready = lsu_sel && shared.awready;
  assign lsu.wready  = lsu_sel && shared.wready;
  assign lsu.bvalid  = lsu_sel && shared.bvalid;
  assign lsu.bresp   = shared.bresp;

endmodule

// ==== hw/addr_xbar.sv ====
`timescale 1ns/1ps

module addr_xbar (
  input  logic          clock,
  input  logic          rst,
  axi_lite_if.slave     up,
  axi_lite_if.master    sram,
  axi_lite_if.rd_master clint
);
  import soc_pkg::*;

  logic  rd_sram;
  logic  rd_clint;
  logic  rd_err;
  logic  wr_req;
  logic  wr_sram;
  logic  wr_clint;
  logic  err_busy;
  logic  err_rd_take;
  logic  err_wr_take;
  logic  err_rvalid;
  logic  err_bvalid;
  resp_t err_code;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Address decode
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign rd_sram  = (up.araddr & sram_hit) == sram_base;
  assign rd_clint = (up.araddr & clint_hit) == clint_base;
  assign rd_err   = !rd_sram && !rd_clint;

  // A pending read goes first
  assign wr_req   = up.awvalid && up.wvalid && !up.arvalid;
  assign wr_sram  = (up.awaddr & sram_hit) == sram_base;
  assign wr_clint = (up.awaddr & clint_hit) == clint_base;

  assign sram.arvalid = up.arvalid && rd_sram;
  assign sram.araddr  = up.araddr;
  assign sram.rready  = up.rready;
  assign sram.awvalid = up.awvalid && wr_sram && !up.arvalid;
  assign sram.awaddr  = up.awaddr;
  assign sram.wvalid  = up.wvalid && wr_sram && !up.arvalid;
  assign sram.wdata   = up.wdata;
  assign sram.wstrb   = up.wstrb;
  assign sram.bready  = up.bready;

  assign clint.arvalid = up.arvalid && rd_clint;
  assign clint.araddr  = up.araddr;
  assign clint.rready  = up.rready;

  assign up.arready = rd_sram ? sram.arready : (rd_clint ? clint.arready : !err_busy);
  assign up.awready = !up.arvalid && (wr_sram ? sram.awready : !err_busy);
  assign up.wready  = !up.arvalid && (wr_sram ? sram.wready : !err_busy);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Error responder
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign err_busy    = err_rvalid || err_bvalid;
  assign err_rd_take = up.arvalid && rd_err && !err_busy;
  assign err_wr_take = wr_req && !wr_sram && !err_busy;

  always_ff @(posedge clock) begin
    if (rst) begin
      err_rvalid <= 1'b0;
      err_bvalid <= 1'b0;
    end else begin
      if (err_rd_take) begin
        err_rvalid <= 1'b1;
      end else if (up.rready) begin
        err_rvalid <= 1'b0;
      end
      if (err_wr_take) begin
        err_bvalid <= 1'b1;
      end else if (up.bready) begin
        err_bvalid <= 1'b0;
      end
    end
  end

  // Timer is read-only, so writes there get slverr
  always_ff @(posedge clock) begin
    if (err_rd_take) begin
      err_code <= resp_decerr;
    end else if (err_wr_take) begin
      err_code <= wr_clint ? resp_slverr : resp_decerr;
    end
  end

  // Only one slave holds a response at a time
  assign up.rvalid = sram.rvalid || clint.rvalid || err_rvalid;
  assign up.rdata  = sram.rvalid ? sram.rdata : (clint.rvalid ? clint.rdata : '0);
  assign up.rresp  = sram.rvalid ? sram.rresp : (clint.rvalid ? clint.rresp : err_code);
  assign up.bvalid = sram.bvalid || err_bvalid;
  assign up.bresp  = sram.bvalid ? sram.bresp : err_code;

endmodule

// ==== hw/sram_slave.sv ====
`timescale 1ns/1ps

module sram_slave (
  input  logic      clock,
  input  logic      rst,
  axi_lite_if.slave bus
);
  import soc_pkg::*;

  logic [data_w-1:0]     mem [sram_words];
  logic [sram_idx_w-1:0] rd_idx;
  logic [sram_idx_w-1:0] wr_idx;
  logic                  rvalid_q;
  logic                  bvalid_q;
  logic [data_w-1:0]     rdata_q;
  logic                  pending;
  logic                  rd_fire;
  logic                  wr_fire;

  // Word index wraps modulo the depth
  assign rd_idx = bus.araddr[sram_idx_w+1:2];
  assign wr_idx = bus.awaddr[sram_idx_w+1:2];

  assign pending = rvalid_q || bvalid_q;

  assign bus.arready = !pending;
  assign bus.awready = !pending && !bus.arvalid;
  assign bus.wready  = !pending && !bus.arvalid;

  assign rd_fire = bus.arvalid && bus.arready;
  assign wr_fire = bus.awvalid && bus.wvalid && bus.awready;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Response state
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clock) begin
    if (rst) begin
      rvalid_q <= 1'b0;
      bvalid_q <= 1'b0;
    end else begin
      if (rd_fire) begin
        rvalid_q <= 1'b1;
      end else if (bus.rready) begin
        rvalid_q <= 1'b0;
      end
      if (wr_fire) begin
        bvalid_q <= 1'b1;
      end else if (bus.bready) begin
        bvalid_q <= 1'b0;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Storage
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clock) begin
    if (rd_fire) begin
      rdata_q <= mem[rd_idx];
    end
    if (wr_fire) begin
      for (int i = 0; i < strb_w; i++) begin
        if (bus.wstrb[i]) begin
          mem[wr_idx][8*i +: 8] <= bus.wdata[8*i +: 8];
        end
      end
    end
  end

  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;
  assign bus.rresp  = resp_okay;
  assign bus.bvalid = bvalid_q;
  assign bus.bresp  = resp_okay;

endmodule

// ==== hw/clint_timer.sv ====
`timescale 1ns/1ps

module clint_timer (
  input  logic         clock,
  input  logic         rst,
  axi_lite_if.rd_slave bus
);
  import soc_pkg::*;

  logic [63:0]       mtime;
  logic [31:0]       shadow_hi;
  logic              rvalid_q;
  logic [data_w-1:0] rdata_q;
  logic              rd_fire;

  assign bus.arready = !rvalid_q;
  assign rd_fire     = bus.arvalid && bus.arready;

  always_ff @(posedge clock) begin
    if (rst) begin
      mtime    <= '0;
      rvalid_q <= 1'b0;
    end else begin
      mtime <= mtime + 64'd1;
      if (rd_fire) begin
        rvalid_q <= 1'b1;
      end else if (bus.rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  // Low word read latches the high half so the pair stays coherent
  always_ff @(posedge clock) begin
    if (rd_fire) begin
      if (!bus.araddr[2]) begin
        rdata_q   <= mtime[31:0];
        shadow_hi <= mtime[63:32];
      end else begin
        rdata_q <= shadow_hi;
      end
    end
  end

  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;
  assign bus.rresp  = resp_okay;

endmodule

// ==== hw/mem_subsystem.sv ====
`timescale 1ns/1ps

module mem_subsystem (
  input  logic                       clock,
  input  logic                       rst,

  input  logic                       fetch_arvalid,
  output logic                       fetch_arready,
  input  logic [soc_pkg::addr_w-1:0] fetch_araddr,
  output logic                       fetch_rvalid,
  input  logic                       fetch_rready,
  output logic [soc_pkg::data_w-1:0] fetch_rdata,
  output soc_pkg::resp_t             fetch_rresp,

  input  logic                       lsu_arvalid,
  output logic                       lsu_arready,
  input  logic [soc_pkg::addr_w-1:0] lsu_araddr,
  output logic                       lsu_rvalid,
  input  logic                       lsu_rready,
  output logic [soc_pkg::data_w-1:0] lsu_rdata,
  output soc_pkg::resp_t             lsu_rresp,
  input  logic                       lsu_awvalid,
  output logic                       lsu_awready,
  input  logic [soc_pkg::addr_w-1:0] lsu_awaddr,
  input  logic                       lsu_wvalid,
  output logic                       lsu_wready,
  input  logic [soc_pkg::data_w-1:0] lsu_wdata,
  input  logic [soc_pkg::strb_w-1:0] lsu_wstrb,
  output logic                       lsu_bvalid,
  input  logic                       lsu_bready,
  output soc_pkg::resp_t             lsu_bresp
);

  axi_lite_if fetch_bus ();
  axi_lite_if lsu_bus ();
  axi_lite_if shared_bus ();
  axi_lite_if sram_bus ();
  axi_lite_if clint_bus ();

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Master ports onto the interfaces
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign fetch_bus.arvalid = fetch_arvalid;
  assign fetch_bus.araddr  = fetch_araddr;
  assign fetch_bus.rready  = fetch_rready;
  assign fetch_arready     = fetch_bus.arready;
  assign fetch_rvalid      = fetch_bus.rvalid;
  assign fetch_rdata       = fetch_bus.rdata;
  assign fetch_rresp       = fetch_bus.rresp;

  assign lsu_bus.arvalid = lsu_arvalid;
  assign lsu_bus.araddr  = lsu_araddr;
  assign lsu_bus.rready  = lsu_rready;
  assign lsu_bus.awvalid = lsu_awvalid;
  assign lsu_bus.awaddr  = lsu_awaddr;
  assign lsu_bus.wvalid  = lsu_wvalid;
  assign lsu_bus.wdata   = lsu_wdata;
  assign lsu_bus.wstrb   = lsu_wstrb;
  assign lsu_bus.bready  = lsu_bready;
  assign lsu_arready     = lsu_bus.arready;
  assign lsu_rvalid      = lsu_bus.rvalid;
  assign lsu_rdata       = lsu_bus.rdata;
  assign lsu_rresp       = lsu_bus.rresp;
  assign lsu_awready     = lsu_bus.awready;
  assign lsu_wready      = lsu_bus.wready;
  assign lsu_bvalid      = lsu_bus.bvalid;
  assign lsu_bresp       = lsu_bus.bresp;

  bus_arbiter u_arbiter (
    .clock  (clock),
    .rst    (rst),
    .fetch  (fetch_bus.rd_slave),
    .lsu    (lsu_bus.slave),
    .shared (shared_bus.master)
  );

  addr_xbar u_xbar (
    .clock (clock),
    .rst   (rst),
    .up    (shared_bus.slave),
    .sram  (sram_bus.master),
    .clint (clint_bus.rd_master)
  );

  sram_slave u_sram (
    .clock (clock),
    .rst   (rst),
    .bus   (sram_bus.slave)
  );

  clint_timer u_clint (
    .clock (clock),
    .rst   (rst),
    .bus   (clint_bus.rd_slave)
  );

endmodule

// ==== testbench/tb_mem_subsystem.sv ====
`timescale 1ns/1ps

module tb_mem_subsystem;
  import soc_pkg::*;

  localparam int n_entries   = 20;
  localparam int cycle_limit = n_entries * 20 + 200;

  typedef enum logic {port_fetch, port_lsu} port_t;
  typedef enum logic [1:0] {kind_read, kind_write, kind_pair} kind_t;

  typedef struct packed {
    port_t       port;
    kind_t       kind;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  strb;
    resp_t       code;
    logic        together;
    logic [7:0]  stall;
  } entry_t;

  logic              clock;
  logic              rst;
  logic              fetch_arvalid;
  logic              fetch_arready;
  logic [addr_w-1:0] fetch_araddr;
  logic              fetch_rvalid;
  logic              fetch_rready;
  logic [data_w-1:0] fetch_rdata;
  resp_t             fetch_rresp;
  logic              lsu_arvalid;
  logic              lsu_arready;
  logic [addr_w-1:0] lsu_araddr;
  logic              lsu_rvalid;
  logic              lsu_rready;
  logic [data_w-1:0] lsu_rdata;
  resp_t             lsu_rresp;
  logic              lsu_awvalid;
  logic              lsu_awready;
  logic [addr_w-1:0] lsu_awaddr;
  logic              lsu_wvalid;
  logic              lsu_wready;
  logic [data_w-1:0] lsu_wdata;
  logic [strb_w-1:0] lsu_wstrb;
  logic              lsu_bvalid;
  logic              lsu_bready;
  resp_t             lsu_bresp;

  entry_t      stim [n_entries];
  logic [31:0] model [sram_words];
  int          n_fill = 0;
  int          errors = 0;
  int          cycle = 0;
  logic [63:0] last_pair;
  logic        have_pair = 1'b0;
  logic [31:0] data_a;
  logic [31:0] data_b;
  resp_t       code_a;
  resp_t       code_b;
  int          done_a;
  int          done_b;

  mem_subsystem u_dut (.*);

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  always @(posedge clock) begin
    cycle = cycle + 1;
    if (cycle >= cycle_limit) begin
      $display("Timeout: no progress after %0d cycles, the run hung", cycle);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Checking and reference model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string msg);
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t: %s, got %h expected %h", $time, msg, got, exp);
    end
  endtask

  function automatic logic in_sram(input logic [31:0] addr);
    return addr >= sram_base && addr < sram_base + 32'h0000_0400;
  endfunction

  // Timer is read-only and anything outside both regions is unmapped
  function automatic resp_t map_code(input logic [31:0] addr, input logic is_write);
    if (in_sram(addr)) begin
      return resp_okay;
    end
    if (addr >= clint_base && addr < clint_base + 32'd8) begin
      return is_write ? resp_slverr : resp_okay;
    end
    return resp_decerr;
  endfunction

  task automatic model_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        model[addr[9:2]][8*b +: 8] = data[8*b +: 8];
      end
    end
  endtask

  task automatic add_entry(input port_t port, input kind_t kind, input logic [31:0] addr,
                           input logic [3:0] strb, input logic together, input logic [7:0] stall);
    entry_t e;
    e.port     = port;
    e.kind     = kind;
    e.addr     = addr;
    e.wdata    = $urandom();
    e.strb     = strb;
    e.code     = map_code(addr, kind == kind_write);
    e.together = together;
    e.stall    = stall;
    stim[n_fill] = e;
    n_fill++;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Bus drivers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic logic [34:0] r_view(input logic on_lsu);
    return on_lsu ? {lsu_rvalid, lsu_rresp, lsu_rdata} : {fetch_rvalid, fetch_rresp, fetch_rdata};
  endfunction

  task automatic drive_read(input logic on_lsu, input logic arvalid, input logic [31:0] araddr,
                            input logic rready);
    if (on_lsu) begin
      lsu_arvalid = arvalid;
      lsu_araddr  = araddr;
      lsu_rready  = rready;
    end else begin
      fetch_arvalid = arvalid;
      fetch_araddr  = araddr;
      fetch_rready  = rready;
    end
  endtask

  task automatic read_word(input port_t port, input logic [31:0] addr, input logic [7:0] stall,
                           output logic [31:0] data, output resp_t code, output int done);
    logic        on_lsu;
    logic [34:0] seen;
    on_lsu = (port == port_lsu);
    @(posedge clock);
    #1;
    drive_read(on_lsu, 1'b1, addr, 1'b0);
    @(negedge clock);
    check_value(64'(on_lsu ? lsu_arready : fetch_arready), 64'd0,
                "arready low in the first cycle of a request");
    while (!(on_lsu ? lsu_arready : fetch_arready)) begin
      @(negedge clock);
    end
    check_value(64'(on_lsu ? lsu_rvalid : fetch_rvalid), 64'd0,
                "rvalid low in the ar handshake cycle");
    @(posedge clock);
    #1;
    drive_read(on_lsu, 1'b0, addr, 1'b0);
    @(negedge clock);
    seen = r_view(on_lsu);
    check_value(64'(seen[34]), 64'd1, $sformatf("rvalid one cycle after ar at %h", addr));
    data = seen[31:0];
    code = resp_t'(seen[33:32]);
    repeat (stall) begin
      @(negedge clock);
      check_value(64'(r_view(on_lsu)), 64'(seen), "r channel held under back-pressure");
    end
    @(posedge clock);
    #1;
    drive_read(on_lsu, 1'b0, addr, 1'b1);
    @(negedge clock);
    check_value(64'(r_view(on_lsu)), 64'(seen), "r channel held until accepted");
    done = cycle;
    @(posedge clock);
    #1;
    drive_read(on_lsu, 1'b0, addr, 1'b0);
  endtask

  task automatic write_word(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, input logic [7:0] stall, output resp_t code);
    @(posedge clock);
    #1;
    lsu_awvalid = 1'b1;
    lsu_awaddr  = addr;
    lsu_wvalid  = 1'b1;
    lsu_wdata   = data;
    lsu_wstrb   = strb;
    @(negedge clock);
    while (!(lsu_awready && lsu_wready)) begin
      check_value(64'(lsu_wready), 64'(lsu_awready), "awready and wready rise together");
      @(negedge clock);
    end
    check_value(64'(lsu_bvalid), 64'd0, "bvalid low in the write handshake cycle");
    @(posedge clock);
    #1;
    lsu_awvalid = 1'b0;
    lsu_wvalid  = 1'b0;
    @(negedge clock);
    check_value(64'(lsu_bvalid), 64'd1, $sformatf("bvalid one cycle after write at %h", addr));
    code = lsu_bresp;
    repeat (stall) begin
      @(negedge clock);
      check_value(64'({lsu_bvalid, lsu_bresp}), 64'({1'b1, code}), "b channel held");
    end
    @(posedge clock);
    #1;
    lsu_bready = 1'b1;
    @(negedge clock);
    check_value(64'({lsu_bvalid, lsu_bresp}), 64'({1'b1, code}), "b channel held until accepted");
    @(posedge clock);
    #1;
    lsu_bready = 1'b0;
  endtask

  task automatic check_read(input entry_t e, input logic [31:0] data, input resp_t code);
    check_value(64'(code), 64'(e.code), $sformatf("read code at %h", e.addr));
    if (e.code == resp_okay && in_sram(e.addr)) begin
      check_value(64'(data), 64'(model[e.addr[9:2]]), $sformatf("read data at %h", e.addr));
    end
  endtask

  task automatic run_entry(input entry_t e);
    logic [31:0] lo;
    logic [31:0] hi;
    resp_t       code;
    int          done;
    case (e.kind)
      kind_write: begin
        write_word(e.addr, e.wdata, e.strb, e.stall, code);
        check_value(64'(code), 64'(e.code), $sformatf("write code at %h", e.addr));
        if (e.code == resp_okay) begin
          model_write(e.addr, e.wdata, e.strb);
        end
      end
      kind_read: begin
        read_word(e.port, e.addr, e.stall, lo, code, done);
        check_read(e, lo, code);
      end
      default: begin
        // Low word first so the high word comes from the shadow
        read_word(e.port, e.addr, e.stall, lo, code, done);
        check_value(64'(code), 64'(resp_okay), "mtime low word code");
        read_word(e.port, e.addr + 32'd4, e.stall, hi, code, done);
        check_value(64'(code), 64'(resp_okay), "mtime high word code");
        if (have_pair) begin
          check_value(64'({hi, lo} > last_pair), 64'd1, "mtime pair increases");
        end
        last_pair = {hi, lo};
        have_pair = 1'b1;
      end
    endcase
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus table and main loop
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    int i;
    void'($urandom(60));
    rst           = 1'b1;
    fetch_arvalid = 1'b0;
    fetch_araddr  = '0;
    fetch_rready  = 1'b0;
    lsu_arvalid   = 1'b0;
    lsu_araddr    = '0;
    lsu_rready    = 1'b0;
    lsu_awvalid   = 1'b0;
    lsu_awaddr    = '0;
    lsu_wvalid    = 1'b0;
    lsu_wdata     = '0;
    lsu_wstrb     = '0;
    lsu_bready    = 1'b0;

    add_entry(port_lsu,   kind_write, 32'h8000_0000, 4'hF, 1'b0, 8'd0);
    add_entry(port_lsu,   kind_write, 32'h8000_0004, 4'hF, 1'b0, 8'd0);
    add_entry(port_lsu,   kind_write, 32'h8000_0008, 4'hF, 1'b0, 8'd0);
    add_entry(port_lsu,   kind_write, 32'h8000_0008, 4'h5, 1'b0, 8'd2);
    add_entry(port_lsu,   kind_write, 32'h8000_0004, 4'h8, 1'b0, 8'd0);
    add_entry(port_lsu,   kind_write, 32'h8000_03FC, 4'hF, 1'b0, 8'd0);
    add_entry(port_lsu,   kind_read,  32'h8000_0008, 4'h0, 1'b0, 8'd3);
    add_entry(port_lsu,   kind_read,  32'h8000_0004, 4'h0, 1'b0, 8'd0);
    add_entry(port_fetch, kind_read,  32'h8000_0000, 4'h0, 1'b0, 8'd0);
    add_entry(port_fetch, kind_read,  32'h8000_0008, 4'h0, 1'b0, 8'd2);
    // Issued together with the next entry
    add_entry(port_lsu,   kind_read,  32'h8000_0004, 4'h0, 1'b1, 8'd2);
    add_entry(port_fetch, kind_read,  32'h8000_03FC, 4'h0, 1'b0, 8'd0);
    add_entry(port_lsu,   kind_read,  32'h1000_0000, 4'h0, 1'b0, 8'd1);
    add_entry(port_lsu,   kind_write, 32'h1000_0000, 4'hF, 1'b0, 8'd1);
    add_entry(port_fetch, kind_read,  32'h0000_0100, 4'h0, 1'b0, 8'd0);
    add_entry(port_lsu,   kind_pair,  32'h0200_0000, 4'h0, 1'b0, 8'd0);
    add_entry(port_lsu,   kind_write, 32'h0200_0000, 4'hF, 1'b0, 8'd0);
    add_entry(port_lsu,   kind_write, 32'h0200_0004, 4'hF, 1'b0, 8'd2);
    add_entry(port_fetch, kind_pair,  32'h0200_0000, 4'h0, 1'b0, 8'd1);
    add_entry(port_lsu,   kind_read,  32'h8000_0000, 4'h0, 1'b0, 8'd0);

    repeat (5) @(posedge clock);
    #1;
    rst = 1'b0;

    i = 0;
    while (i < n_entries) begin
      if (stim[i].together) begin
        fork
          read_word(stim[i].port, stim[i].addr, stim[i].stall, data_a, code_a, done_a);
          read_word(stim[i+1].port, stim[i+1].addr, stim[i+1].stall, data_b, code_b, done_b);
        join
        check_read(stim[i], data_a, code_a);
        check_read(stim[i+1], data_b, code_b);
        check_value(64'(done_a < done_b), 64'd1, "load/store response ahead of fetch");
        i = i + 2;
      end else begin
        run_entry(stim[i]);
        i = i + 1;
      end
    end

    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
hw/soc_pkg.sv
hw/axi_lite_if.sv
hw/bus_arbiter.sv
hw/addr_xbar.sv
hw/sram_slave.sv
hw/clint_timer.sv
hw/mem_subsystem.sv
testbench/tb_mem_subsystem.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the memory subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps \
  --top-module tb_mem_subsystem \
  -f sim.f \
  -o tb_mem_subsystem

./obj_dir/tb_mem_subsystem | tee sim.log

if grep -q "CHECKS FAILED" sim.log; then
  echo "Simulation reported a failure, see sim.log"
  exit 1
fi

echo "Simulation completed without failure"
exit 0
